//--- compile.f
design/mem_edge_pkg.sv
design/write_heap_ram.sv
design/req_fifo.sv
design/afu_edge.sv
design/fiu_edge.sv
design/mem_edge_top.sv
tb/tb_clock_gen.sv
tb/mem_edge_tb.sv

//--- design/afu_edge.sv
// ====================
// AFU side edge
// Allocates heap slots, stores write beats in the heap and forwards
// one header per packet toward the FIU side
// ====================

`timescale 1ns/1ps

module afu_edge
    import mem_edge_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       afu_c1_valid,
    input  t_line_addr afu_c1_addr,
    input  t_mdata     afu_c1_mdata,
    input  t_cl_num    afu_c1_len,
    input  logic       afu_c1_sop,
    input  t_line_data afu_c1_data,
    output logic       afu_c1_alm_full,
    output logic       heap_wen,
    output t_heap_addr heap_waddr,
    output t_line_data heap_wdata,
    output logic       hdr_enq_en,
    output t_wr_hdr    hdr_enq_data,
    input  logic       hdr_alm_full,
    input  logic       heap_free,
    input  t_heap_idx  heap_free_idx
);

    // One bit per slot, set while the slot is free
    logic [N_HEAP_ENTRIES-1:0] free_slots;
    logic [HEAP_IDX_W:0]       n_free;
    t_heap_idx                 alloc_idx;
    logic                      alloc_en;

    // Packet in progress, with the fields captured at sop
    logic       in_pkt;
    t_cl_num    beat_q;
    t_heap_idx  pkt_idx;
    t_line_addr pkt_addr;
    t_mdata     pkt_mdata;
    t_cl_num    pkt_len;

    // Fields of the current beat
    t_heap_idx  cur_idx;
    t_cl_num    cur_beat;
    t_line_addr cur_addr;
    t_mdata     cur_mdata;
    t_cl_num    cur_len;
    logic       last_beat;

    // ====================
    // Slot allocation

    // Scan downward so the lowest free slot wins, counting free slots on the way
    always_comb
    begin
        alloc_idx = '0;
        n_free = '0;
        for (int i = N_HEAP_ENTRIES - 1; i >= 0; i--)
        begin
            if (free_slots[i])
            begin
                alloc_idx = t_heap_idx'(i);
                n_free = n_free + 1'b1;
            end
        end
    end

    assign alloc_en = afu_c1_valid && afu_c1_sop;

    // Keep two slots in reserve for packets the AFU sends after the assertion
    assign afu_c1_alm_full = hdr_alm_full || (n_free <= 2);

    // ====================
    // Beat handling

    // The sop beat carries the packet fields; later beats reuse the held copy
    always_comb
    begin
        cur_idx = afu_c1_sop ? alloc_idx : pkt_idx;
        cur_beat = afu_c1_sop ? t_cl_num'(0) : beat_q;
        cur_addr = afu_c1_sop ? afu_c1_addr : pkt_addr;
        cur_mdata = afu_c1_sop ? afu_c1_mdata : pkt_mdata;
        cur_len = afu_c1_sop ? afu_c1_len : pkt_len;
        last_beat = (cur_beat == cur_len);
    end

    assign heap_wen = afu_c1_valid;
    assign heap_waddr = {cur_idx, cur_beat};
    assign heap_wdata = afu_c1_data;

    // The header leaves only once every beat of its packet is stored
    assign hdr_enq_en = afu_c1_valid && last_beat;
    assign hdr_enq_data = {cur_addr, cur_mdata, cur_len, cur_idx};

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            free_slots <= '1;
            in_pkt <= 1'b0;
            beat_q <= '0;
        end
        else
        begin
            // A freed slot is never the one being allocated in the same cycle
            if (heap_free)
            begin
                free_slots[heap_free_idx] <= 1'b1;
            end
            if (alloc_en)
            begin
                free_slots[alloc_idx] <= 1'b0;
            end

            if (afu_c1_valid)
            begin
                in_pkt <= !last_beat;
                beat_q <= cur_beat + 1'b1;
            end
        end

        if (alloc_en)
        begin
            pkt_idx <= alloc_idx;
            pkt_addr <= afu_c1_addr;
            pkt_mdata <= afu_c1_mdata;
            pkt_len <= afu_c1_len;
        end
    end

    // ====================
    // Checks

    a_slot_available: assert property (@(posedge clk) disable iff (reset)
        alloc_en |-> (n_free != '0));

    // Only the first beat of a packet carries sop
    a_beat_order: assert property (@(posedge clk) disable iff (reset)
        afu_c1_valid |-> (afu_c1_sop == !in_pkt));

    // The FIU side only returns slots that were handed out
    a_free_in_use: assert property (@(posedge clk) disable iff (reset)
        heap_free |-> !free_slots[heap_free_idx]);

endmodule

//--- design/fiu_edge.sv
// ====================
// FIU side edge
// Forwards AFU reads with page table reads injected, splits read
// responses and expands write headers into flits read from the heap
// ====================

`timescale 1ns/1ps

module fiu_edge
    import mem_edge_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       afu_c0_valid,
    input  t_line_addr afu_c0_addr,
    input  t_mdata     afu_c0_mdata,
    output logic       afu_c0_alm_full,
    input  logic       fiu_c0_alm_full,
    output logic       fiu_c0_valid,
    output t_line_addr fiu_c0_addr,
    output t_mdata     fiu_c0_mdata,
    input  logic       pt_read_en,
    input  t_line_addr pt_read_addr,
    output logic       pt_read_rdy,
    output logic       pt_read_data_en,
    output t_line_data pt_read_data,
    input  logic       fiu_rd_rsp_valid,
    input  t_mdata     fiu_rd_rsp_mdata,
    input  t_line_data fiu_rd_rsp_data,
    output logic       afu_rd_rsp_valid,
    output t_mdata     afu_rd_rsp_mdata,
    output t_line_data afu_rd_rsp_data,
    input  t_wr_hdr    hdr_first,
    input  logic       hdr_not_empty,
    output logic       hdr_deq_en,
    output t_heap_addr heap_raddr,
    input  t_line_data heap_rdata,
    output logic       heap_free,
    output t_heap_idx  heap_free_idx,
    input  logic       fiu_c1_alm_full,
    output logic       fiu_c1_valid,
    output t_line_addr fiu_c1_addr,
    output t_mdata     fiu_c1_mdata,
    output logic       fiu_c1_sop,
    output t_line_data fiu_c1_data
);

    // ====================
    // Read requests

    t_edge_state pt_state;
    t_line_addr  pt_addr;
    t_mdata      pt_mdata;
    logic        pt_emit;

    // Walker reads carry only the reserved bit in their metadata
    assign pt_mdata = t_mdata'(1) << PT_MDATA_IDX;

    // A walk request goes out in a cycle the AFU leaves the channel idle
    assign pt_emit = (pt_state == PT_PENDING) && !afu_c0_valid;
    assign pt_read_rdy = (pt_state == PT_IDLE);

    // While a walk waits, keep the AFU moving so an idle cycle comes along
    assign afu_c0_alm_full = fiu_c0_alm_full && (pt_state != PT_PENDING);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pt_state <= PT_IDLE;
            fiu_c0_valid <= 1'b0;
        end
        else
        begin
            // The walker only asks while idle, so the two cases never overlap
            if (pt_read_en)
            begin
                pt_state <= PT_PENDING;
            end
            else if (pt_emit)
            begin
                pt_state <= PT_IDLE;
            end
            fiu_c0_valid <= afu_c0_valid || pt_emit;
        end

        if (pt_read_en)
        begin
            pt_addr <= pt_read_addr;
        end

        fiu_c0_addr <= pt_emit ? pt_addr : afu_c0_addr;
        fiu_c0_mdata <= pt_emit ? pt_mdata : afu_c0_mdata;
    end

    // ====================
    // Read responses

    logic is_pt_rsp;

    // Responses tagged with the reserved bit belong to the walker
    assign is_pt_rsp = fiu_rd_rsp_mdata[PT_MDATA_IDX];
    assign pt_read_data_en = fiu_rd_rsp_valid && is_pt_rsp;
    assign pt_read_data = fiu_rd_rsp_data;
    assign afu_rd_rsp_valid = fiu_rd_rsp_valid && !is_pt_rsp;
    assign afu_rd_rsp_mdata = fiu_rd_rsp_mdata;
    assign afu_rd_rsp_data = fiu_rd_rsp_data;

    // ====================
    // Write expansion

    t_line_addr first_addr;
    t_mdata     first_mdata;
    t_cl_num    first_len;
    t_heap_idx  first_idx;

    // Stage 1 walks the beats of one packet
    logic       stg1_valid;
    t_line_addr stg1_addr;
    t_mdata     stg1_mdata;
    logic       stg1_sop;
    t_cl_num    stg1_beat;
    t_cl_num    stg1_rem;
    t_heap_idx  stg1_idx;

    // Stages 2 and 3 wait for the heap read
    logic       stg2_valid;
    t_line_addr stg2_addr;
    t_mdata     stg2_mdata;
    logic       stg2_sop;
    logic       stg3_valid;
    t_line_addr stg3_addr;
    t_mdata     stg3_mdata;
    logic       stg3_sop;

    logic may_fire;
    logic stg1_done;

    assign {first_addr, first_mdata, first_len, first_idx} = hdr_first;

    assign may_fire = !fiu_c1_alm_full;

    // The packet finishes when its last beat leaves stage 1
    assign stg1_done = may_fire && stg1_valid && (stg1_rem == '0);

    // Refill stage 1 when it is empty or about to empty
    assign hdr_deq_en = hdr_not_empty && (stg1_done || !stg1_valid);

    // Heap data for this beat lines up with stage 3
    assign heap_raddr = {stg1_idx, stg1_beat};

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            stg1_valid <= 1'b0;
            stg2_valid <= 1'b0;
            stg3_valid <= 1'b0;
            heap_free <= 1'b0;
        end
        else
        begin
            if (hdr_deq_en)
            begin
                stg1_valid <= 1'b1;
            end
            else if (stg1_done)
            begin
                stg1_valid <= 1'b0;
            end

            // Stage 2 takes a bubble whenever stage 1 holds
            stg2_valid <= may_fire && stg1_valid;
            stg3_valid <= stg2_valid;
            heap_free <= stg1_done;
        end

        if (hdr_deq_en)
        begin
            stg1_addr <= first_addr;
            stg1_mdata <= first_mdata;
            stg1_sop <= 1'b1;
            stg1_beat <= '0;
            stg1_rem <= first_len;
            stg1_idx <= first_idx;
        end
        else if (may_fire && stg1_valid)
        begin
            stg1_sop <= 1'b0;
            stg1_beat <= stg1_beat + 1'b1;
            stg1_rem <= stg1_rem - 1'b1;
        end

        // Low address bits carry the beat number
        stg2_addr <= {stg1_addr[LINE_ADDR_W-1:CL_NUM_W], stg1_addr[CL_NUM_W-1:0] | stg1_beat};
        stg2_mdata <= stg1_mdata;
        stg2_sop <= stg1_sop;

        stg3_addr <= stg2_addr;
        stg3_mdata <= stg2_mdata;
        stg3_sop <= stg2_sop;

        heap_free_idx <= stg1_idx;
    end

    assign fiu_c1_valid = stg3_valid;
    assign fiu_c1_addr = stg3_addr;
    assign fiu_c1_mdata = stg3_mdata;
    assign fiu_c1_sop = stg3_sop;
    assign fiu_c1_data = heap_rdata;

    // Walker responses are told apart only by this bit
    a_afu_mdata_reserved: assert property (@(posedge clk) disable iff (reset)
        afu_c0_valid |-> !afu_c0_mdata[PT_MDATA_IDX]);

endmodule

//--- design/mem_edge_pkg.sv
// ====================
// Memory edge shared definitions
// Widths, typedefs, heap and FIFO sizing and the walker tracker states
// used by both edges of the request pipeline
// ====================

package mem_edge_pkg;

    // ====================
    // Field widths

    localparam int LINE_ADDR_W = 16;
    localparam int LINE_DATA_W = 32;
    localparam int MDATA_W = 8;

    // Beat number, also the packet length encoded as beats minus one
    localparam int CL_NUM_W = 2;

    // ====================
    // Sizing

    localparam int N_HEAP_ENTRIES = 8;

    // Every slot holds up to four beats of one packet
    localparam int N_HEAP_WORDS = N_HEAP_ENTRIES * 4;
    localparam int HEAP_IDX_W = $clog2(N_HEAP_ENTRIES);

    // Metadata bit reserved for page table walker reads
    localparam int PT_MDATA_IDX = 7;

    localparam int TX_ALM_FULL_THRESHOLD = 4;

    // Two spare entries absorb the requests in flight when almost-full rises
    localparam int HDR_FIFO_ENTRIES = TX_ALM_FULL_THRESHOLD + 2;

    // ====================
    // Types

    typedef logic [LINE_ADDR_W-1:0] t_line_addr;
    typedef logic [LINE_DATA_W-1:0] t_line_data;
    typedef logic [MDATA_W-1:0] t_mdata;
    typedef logic [CL_NUM_W-1:0] t_cl_num;
    typedef logic [HEAP_IDX_W-1:0] t_heap_idx;

    // Heap word address is the slot index followed by the beat number
    typedef logic [HEAP_IDX_W+CL_NUM_W-1:0] t_heap_addr;

    // Write header packed as {address, mdata, length, heap index}
    localparam int WR_HDR_W = LINE_ADDR_W + MDATA_W + CL_NUM_W + HEAP_IDX_W;
    typedef logic [WR_HDR_W-1:0] t_wr_hdr;

    // Page table read tracker in the FIU edge
    typedef enum logic
    {
        PT_IDLE,
        PT_PENDING
    } t_edge_state;

endpackage

//--- design/mem_edge_top.sv
// ====================
// Memory edge top level
// Joins the AFU and FIU edges through the write heap and header FIFO
// ====================

`timescale 1ns/1ps

module mem_edge_top
    import mem_edge_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    // AFU side
    input  logic       afu_c0_valid,
    input  t_line_addr afu_c0_addr,
    input  t_mdata     afu_c0_mdata,
    output logic       afu_c0_alm_full,
    input  logic       afu_c1_valid,
    input  t_line_addr afu_c1_addr,
    input  t_mdata     afu_c1_mdata,
    input  t_cl_num    afu_c1_len,
    input  logic       afu_c1_sop,
    input  t_line_data afu_c1_data,
    output logic       afu_c1_alm_full,
    output logic       afu_rd_rsp_valid,
    output t_mdata     afu_rd_rsp_mdata,
    output t_line_data afu_rd_rsp_data,
    output logic       afu_wr_rsp_valid,
    output t_mdata     afu_wr_rsp_mdata,

    // FIU side
    output logic       fiu_c0_valid,
    output t_line_addr fiu_c0_addr,
    output t_mdata     fiu_c0_mdata,
    output logic       fiu_c1_valid,
    output t_line_addr fiu_c1_addr,
    output t_mdata     fiu_c1_mdata,
    output logic       fiu_c1_sop,
    output t_line_data fiu_c1_data,
    input  logic       fiu_c0_alm_full,
    input  logic       fiu_c1_alm_full,
    input  logic       fiu_rd_rsp_valid,
    input  t_mdata     fiu_rd_rsp_mdata,
    input  t_line_data fiu_rd_rsp_data,
    input  logic       fiu_wr_rsp_valid,
    input  t_mdata     fiu_wr_rsp_mdata,

    // Page table walker
    input  logic       pt_read_en,
    input  t_line_addr pt_read_addr,
    output logic       pt_read_rdy,
    output logic       pt_read_data_en,
    output t_line_data pt_read_data
);

    logic       heap_wen;
    t_heap_addr heap_waddr;
    t_line_data heap_wdata;
    t_heap_addr heap_raddr;
    t_line_data heap_rdata;
    logic       heap_free;
    t_heap_idx  heap_free_idx;

    logic       hdr_enq_en;
    t_wr_hdr    hdr_enq_data;
    logic       hdr_alm_full;
    logic       hdr_deq_en;
    t_wr_hdr    hdr_first;
    logic       hdr_not_empty;

    // Write responses need no processing
    assign afu_wr_rsp_valid = fiu_wr_rsp_valid;
    assign afu_wr_rsp_mdata = fiu_wr_rsp_mdata;

    afu_edge afu_edge_i
    (
        .clk, .reset,
        .afu_c1_valid, .afu_c1_addr, .afu_c1_mdata, .afu_c1_len, .afu_c1_sop,
        .afu_c1_data, .afu_c1_alm_full,
        .heap_wen, .heap_waddr, .heap_wdata,
        .hdr_enq_en, .hdr_enq_data, .hdr_alm_full,
        .heap_free, .heap_free_idx
    );

    req_fifo req_fifo_i
    (
        .clk, .reset,
        .enq_en(hdr_enq_en),
        .enq_data(hdr_enq_data),
        .alm_full(hdr_alm_full),
        .first(hdr_first),
        .deq_en(hdr_deq_en),
        .not_empty(hdr_not_empty)
    );

    write_heap_ram write_heap_ram_i
    (
        .clk,
        .wen(heap_wen),
        .waddr(heap_waddr),
        .wdata(heap_wdata),
        .raddr(heap_raddr),
        .rdata(heap_rdata)
    );

    fiu_edge fiu_edge_i
    (
        .clk, .reset,
        .afu_c0_valid, .afu_c0_addr, .afu_c0_mdata, .afu_c0_alm_full,
        .fiu_c0_alm_full, .fiu_c0_valid, .fiu_c0_addr, .fiu_c0_mdata,
        .pt_read_en, .pt_read_addr, .pt_read_rdy, .pt_read_data_en, .pt_read_data,
        .fiu_rd_rsp_valid, .fiu_rd_rsp_mdata, .fiu_rd_rsp_data,
        .afu_rd_rsp_valid, .afu_rd_rsp_mdata, .afu_rd_rsp_data,
        .hdr_first, .hdr_not_empty, .hdr_deq_en,
        .heap_raddr, .heap_rdata, .heap_free, .heap_free_idx,
        .fiu_c1_alm_full, .fiu_c1_valid, .fiu_c1_addr, .fiu_c1_mdata, .fiu_c1_sop,
        .fiu_c1_data
    );

endmodule

//--- design/req_fifo.sv
// ====================
// Write header FIFO
// Small circular buffer with a fill counter and an almost-full level
// ====================

`timescale 1ns/1ps

module req_fifo
    import mem_edge_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    enq_en,
    input  t_wr_hdr enq_data,
    output logic    alm_full,
    output t_wr_hdr first,
    input  logic    deq_en,
    output logic    not_empty
);

    localparam int PTR_W = $clog2(HDR_FIFO_ENTRIES);
    localparam int CNT_W = $clog2(HDR_FIFO_ENTRIES + 1);

    t_wr_hdr mem [HDR_FIFO_ENTRIES];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Head entry is visible without a read cycle
    assign first = mem[rd_ptr];
    assign not_empty = (count != '0);
    assign alm_full = (count >= CNT_W'(TX_ALM_FULL_THRESHOLD));

    always_ff @(posedge clk)
    begin
        if (enq_en)
        begin
            mem[wr_ptr] <= enq_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            // Pointers wrap at the depth, which need not be a power of two
            if (enq_en)
            begin
                wr_ptr <= (wr_ptr == PTR_W'(HDR_FIFO_ENTRIES - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (deq_en)
            begin
                rd_ptr <= (rd_ptr == PTR_W'(HDR_FIFO_ENTRIES - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(enq_en) - CNT_W'(deq_en);
        end
    end

    // The AFU edge must stop before the FIFO fills
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        enq_en |-> (count < CNT_W'(HDR_FIFO_ENTRIES)));

    // The FIU edge only pops a header it has seen
    a_no_underflow: assert property (@(posedge clk) disable iff (reset)
        deq_en |-> not_empty);

endmodule

//--- design/write_heap_ram.sv
// ====================
// Write heap memory
// Simple dual-port RAM holding write beats between the two edges
// ====================

`timescale 1ns/1ps

module write_heap_ram
    import mem_edge_pkg::*;
(
    input  logic       clk,
    input  logic       wen,
    input  t_heap_addr waddr,
    input  t_line_data wdata,
    input  t_heap_addr raddr,
    output t_line_data rdata
);

    t_line_data mem [N_HEAP_WORDS];

    // Write port is registered once before it reaches the array
    logic       wen_q;
    t_heap_addr waddr_q;
    t_line_data wdata_q;

    // Array read result, ahead of the output register
    t_line_data rd_q;

    always_ff @(posedge clk)
    begin
        wen_q <= wen;
        waddr_q <= waddr;
        wdata_q <= wdata;

        if (wen_q)
        begin
            mem[waddr_q] <= wdata_q;
        end
    end

    // Two cycle read with no bypass of the pending write
    always_ff @(posedge clk)
    begin
        rd_q <= mem[raddr];
        rdata <= rd_q;
    end

endmodule

//--- tb/mem_edge_tb.sv
// ====================
// Memory edge testbench
// Runs the operations of the vector file through the DUT, models the FIU
// and walker sides and checks every output against the vectors
// ====================

`timescale 1ns/1ps

module mem_edge_tb
    import mem_edge_pkg::*;
();

    localparam int DRIVE_DELAY = 1;

    logic       clk;
    logic       reset;

    logic       afu_c0_valid;
    t_line_addr afu_c0_addr;
    t_mdata     afu_c0_mdata;
    logic       afu_c0_alm_full;
    logic       afu_c1_valid;
    t_line_addr afu_c1_addr;
    t_mdata     afu_c1_mdata;
    t_cl_num    afu_c1_len;
    logic       afu_c1_sop;
    t_line_data afu_c1_data;
    logic       afu_c1_alm_full;
    logic       afu_rd_rsp_valid;
    t_mdata     afu_rd_rsp_mdata;
    t_line_data afu_rd_rsp_data;
    logic       afu_wr_rsp_valid;
    t_mdata     afu_wr_rsp_mdata;
    logic       fiu_c0_valid;
    t_line_addr fiu_c0_addr;
    t_mdata     fiu_c0_mdata;
    logic       fiu_c1_valid;
    t_line_addr fiu_c1_addr;
    t_mdata     fiu_c1_mdata;
    logic       fiu_c1_sop;
    t_line_data fiu_c1_data;
    logic       fiu_c0_alm_full;
    logic       fiu_c1_alm_full;
    logic       fiu_rd_rsp_valid;
    t_mdata     fiu_rd_rsp_mdata;
    t_line_data fiu_rd_rsp_data;
    logic       fiu_wr_rsp_valid;
    t_mdata     fiu_wr_rsp_mdata;
    logic       pt_read_en;
    t_line_addr pt_read_addr;
    logic       pt_read_rdy;
    logic       pt_read_data_en;
    t_line_data pt_read_data;

    // Expected write flits packed as {last, sop, addr, mdata, data}, in issue order
    logic [57:0] exp_flits [$];
    logic [57:0] flit;

    // Heap slots that hold a packet whose last flit has not reached the FIU
    int         slots_used = 0;

    // Read request expected at the FIU in the current cycle
    logic       exp_c0_valid = 1'b0;
    t_line_addr exp_c0_addr;
    t_mdata     exp_c0_mdata;

    // A walker request waits here until the AFU leaves a gap
    logic       pt_pending = 1'b0;
    t_line_addr pt_addr_model;

    logic       c1_hold_seen = 1'b0;
    integer     seed = 32'hdd1ccf5e;
    integer     fd;
    int         n_ops;
    int         n_read;
    logic [7:0] op;
    logic [8*160-1:0] line;
    int         cycle_count = 0;
    int         cycle_limit = 200;

    tb_clock_gen tb_clock_gen_i (.clk, .reset);

    mem_edge_top mem_edge_top_i (.*);

    // ====================
    // Reporting

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected)
        begin
            stop_with_error($sformatf("Error: %s expected %0h got %0h", name, expected, actual));
        end
    endtask

    // ====================
    // Driving

    // Step to the drive point of the next cycle, where every pulse drops
    // and the FIU back-pressure is redrawn
    task automatic next_cycle();
        @(posedge clk);
        #(DRIVE_DELAY);
        afu_c0_valid = 1'b0;
        afu_c1_valid = 1'b0;
        afu_c1_sop = 1'b0;
        pt_read_en = 1'b0;
        fiu_rd_rsp_valid = 1'b0;
        fiu_wr_rsp_valid = 1'b0;
        fiu_c0_alm_full = (($random(seed) & 7) == 0);
        fiu_c1_alm_full = (($random(seed) & 3) < 2);
    endtask

    task automatic read_field(output logic [31:0] value);
        int n;
        n = $fscanf(fd, "%h", value);
        if (n != 1)
        begin
            stop_with_error("A line of the vector file is missing a field");
        end
    endtask

    // Count the operations first so the cycle limit fits the test
    task automatic count_ops();
        int n;
        fd = $fopen("tb/mem_edge_vectors.txt", "r");
        if (fd == 0)
        begin
            stop_with_error("Could not open the vector file tb/mem_edge_vectors.txt");
        end
        n_ops = 0;
        n = $fscanf(fd, " %c", op);
        while (n == 1)
        begin
            if (op != "#")
            begin
                n_ops++;
            end
            n = $fgets(line, fd);
            n = $fscanf(fd, " %c", op);
        end
        $fclose(fd);
    endtask

    task automatic run_op(input logic [7:0] code);
        logic [31:0] addr;
        logic [31:0] mdata;
        logic [31:0] len;
        logic [31:0] data;
        t_line_addr  beat_addr;
        case (code)
            "R":
            begin
                read_field(addr);
                read_field(mdata);
                while (afu_c0_alm_full)
                begin
                    next_cycle();
                end
                afu_c0_valid = 1'b1;
                afu_c0_addr = t_line_addr'(addr);
                afu_c0_mdata = t_mdata'(mdata);
                next_cycle();
            end
            "P":
            begin
                read_field(addr);
                // The walker may only ask while no walk is pending
                while (!pt_read_rdy)
                begin
                    next_cycle();
                end
                pt_read_en = 1'b1;
                pt_read_addr = t_line_addr'(addr);
                next_cycle();
            end
            "W":
            begin
                read_field(addr);
                read_field(mdata);
                read_field(len);
                if (len > 3)
                begin
                    stop_with_error("A write length in the vector file is above three");
                end
                while (afu_c1_alm_full)
                begin
                    c1_hold_seen = 1'b1;
                    next_cycle();
                end
                for (int beat = 0; beat <= int'(len); beat++)
                begin
                    read_field(data);
                    afu_c1_valid = 1'b1;
                    afu_c1_sop = (beat == 0);
                    afu_c1_addr = t_line_addr'(addr);
                    afu_c1_mdata = t_mdata'(mdata);
                    afu_c1_len = t_cl_num'(len);
                    afu_c1_data = data;
                    // Beat number lands in the low address bits of each flit
                    beat_addr = t_line_addr'(addr) | t_line_addr'(beat);
                    exp_flits.push_back({(beat == int'(len)), (beat == 0), beat_addr,
                                         t_mdata'(mdata), data});
                    next_cycle();
                end
            end
            "S":
            begin
                read_field(mdata);
                read_field(data);
                fiu_rd_rsp_valid = 1'b1;
                fiu_rd_rsp_mdata = t_mdata'(mdata);
                fiu_rd_rsp_data = data;
                next_cycle();
            end
            "K":
            begin
                read_field(mdata);
                fiu_wr_rsp_valid = 1'b1;
                fiu_wr_rsp_mdata = t_mdata'(mdata);
                next_cycle();
            end
            default:
            begin
                stop_with_error("The vector file holds an unknown operation");
            end
        endcase
    endtask

    // ====================
    // Checking and FIU model

    // Outputs are settled mid-cycle, so everything is sampled on the falling edge
    always @(negedge clk)
    begin
        if (!reset)
        begin
            check_value("fiu_c0_valid", fiu_c0_valid, exp_c0_valid);
            if (exp_c0_valid)
            begin
                check_value("fiu_c0_addr", fiu_c0_addr, exp_c0_addr);
                check_value("fiu_c0_mdata", fiu_c0_mdata, exp_c0_mdata);
            end
            check_value("pt_read_rdy", pt_read_rdy, !pt_pending);
            check_value("afu_c0_alm_full", afu_c0_alm_full, fiu_c0_alm_full && !pt_pending);

            // Responses split on the reserved metadata bit in the same cycle
            check_value("afu_rd_rsp_valid", afu_rd_rsp_valid,
                        fiu_rd_rsp_valid && !fiu_rd_rsp_mdata[PT_MDATA_IDX]);
            check_value("pt_read_data_en", pt_read_data_en,
                        fiu_rd_rsp_valid && fiu_rd_rsp_mdata[PT_MDATA_IDX]);
            if (afu_rd_rsp_valid)
            begin
                check_value("afu_rd_rsp_mdata", afu_rd_rsp_mdata, fiu_rd_rsp_mdata);
                check_value("afu_rd_rsp_data", afu_rd_rsp_data, fiu_rd_rsp_data);
            end
            if (pt_read_data_en)
            begin
                check_value("pt_read_data", pt_read_data, fiu_rd_rsp_data);
            end
            check_value("afu_wr_rsp_valid", afu_wr_rsp_valid, fiu_wr_rsp_valid);
            if (fiu_wr_rsp_valid)
            begin
                check_value("afu_wr_rsp_mdata", afu_wr_rsp_mdata, fiu_wr_rsp_mdata);
            end

            if (fiu_c1_valid)
            begin
                if (exp_flits.size() == 0)
                begin
                    stop_with_error("A write flit reached the FIU with no beat outstanding");
                end
                flit = exp_flits.pop_front();
                check_value("fiu_c1_sop", fiu_c1_sop, flit[56]);
                check_value("fiu_c1_addr", fiu_c1_addr, flit[55:40]);
                check_value("fiu_c1_mdata", fiu_c1_mdata, flit[39:32]);
                check_value("fiu_c1_data", fiu_c1_data, flit[31:0]);
                // The slot is free again in the cycle its last flit reaches the FIU
                if (flit[57])
                begin
                    slots_used = slots_used - 1;
                end
            end

            // Two or fewer free slots must hold the AFU back
            if (slots_used >= N_HEAP_ENTRIES - 2)
            begin
                check_value("afu_c1_alm_full", afu_c1_alm_full, 1'b1);
            end
            // A slot is taken at the edge that samples the sop beat
            if (afu_c1_valid && afu_c1_sop)
            begin
                slots_used = slots_used + 1;
            end

            // AFU reads win the channel and a walk waits for the first idle cycle
            exp_c0_valid = 1'b0;
            if (afu_c0_valid)
            begin
                exp_c0_valid = 1'b1;
                exp_c0_addr = afu_c0_addr;
                exp_c0_mdata = afu_c0_mdata;
            end
            else if (pt_pending)
            begin
                exp_c0_valid = 1'b1;
                exp_c0_addr = pt_addr_model;
                exp_c0_mdata = '0;
                exp_c0_mdata[PT_MDATA_IDX] = 1'b1;
                pt_pending = 1'b0;
            end
            if (pt_read_en)
            begin
                pt_pending = 1'b1;
                pt_addr_model = pt_read_addr;
            end
        end
    end

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit)
        begin
            stop_with_error("The run timed out before all operations completed");
        end
    end

    // ====================
    // Main sequence

    initial
    begin
        afu_c0_valid = 1'b0;
        afu_c0_addr = '0;
        afu_c0_mdata = '0;
        afu_c1_valid = 1'b0;
        afu_c1_addr = '0;
        afu_c1_mdata = '0;
        afu_c1_len = '0;
        afu_c1_sop = 1'b0;
        afu_c1_data = '0;
        fiu_c0_alm_full = 1'b0;
        fiu_c1_alm_full = 1'b0;
        fiu_rd_rsp_valid = 1'b0;
        fiu_rd_rsp_mdata = '0;
        fiu_rd_rsp_data = '0;
        fiu_wr_rsp_valid = 1'b0;
        fiu_wr_rsp_mdata = '0;
        pt_read_en = 1'b0;
        pt_read_addr = '0;

        count_ops();
        cycle_limit = 20 * n_ops + 200;

        fd = $fopen("tb/mem_edge_vectors.txt", "r");
        wait (!reset);

        n_read = $fscanf(fd, " %c", op);
        while (n_read == 1)
        begin
            if (op == "#")
            begin
                n_read = $fgets(line, fd);
            end
            else
            begin
                run_op(op);
            end
            n_read = $fscanf(fd, " %c", op);
        end
        $fclose(fd);

        // Let the pipeline drain, then watch a few idle cycles
        while ((exp_flits.size() != 0) || pt_pending)
        begin
            next_cycle();
        end
        repeat (4) next_cycle();

        if (!c1_hold_seen)
        begin
            stop_with_error("afu_c1_alm_full never held back a write packet");
        end
        else
        begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

//--- tb/mem_edge_vectors.txt
# R addr mdata | P addr | S mdata data | K mdata (all hex)
# W addr mdata len data0 .. data[len], len is beats minus one
R 1000 01
R 1040 02
P 2a40
R 1080 03
R 10c0 04
S 01 c0de0001
S 80 5eed0001
K 11
S 02 c0de0002
W 0100 10 0 a0000000
W 0204 11 1 a1000000 a1000001
W 0308 12 3 a2000000 a2000001 a2000002 a2000003
W 0402 13 1 a3000000 a3000001
P 2b80
W 0500 14 3 a4000000 a4000001 a4000002 a4000003
W 0600 15 0 a5000000
W 0700 16 3 a6000000 a6000001 a6000002 a6000003
W 0800 17 3 a7000000 a7000001 a7000002 a7000003
W 0900 18 0 a8000000
W 0a00 19 1 a9000000 a9000001
W 0b00 1a 3 aa000000 aa000001 aa000002 aa000003
R 1100 05
W 0c00 1b 3 ab000000 ab000001 ab000002 ab000003
W 0d00 1c 0 ac000000
K 1c
W 0e00 1d 3 ad000000 ad000001 ad000002 ad000003
W 0f00 1e 1 ae000000 ae000001
S 81 5eed0002
R 1140 06
K 7f

//--- tb/tb_clock_gen.sv
// ====================
// Testbench clock and reset
// 100 ns clock with reset held for the first two cycles
// ====================

`timescale 1ns/1ps

module tb_clock_gen
(
    output logic clk,
    output logic reset
);

    localparam int HALF_PERIOD = 50;

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #HALF_PERIOD clk = ~clk;
        end
    end

    // Reset drops just after the second rising edge, like any other input
    initial
    begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule
